/* design/fifo_sdram_pkg.sv */
package fifo_sdram_pkg;

   // one acquisition sample and one stored memory word.
   localparam int SAMPLE_WIDTH = 16;

   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // words are interleaved over the banks by the low address bits.
   localparam int NUM_BANKS      = 4;
   localparam int BANK_SEL_WIDTH = 2;

   // cycles a bank stays not ready after it accepts a command.
   localparam int BANK_BUSY    = 3;
   localparam int BANK_LATENCY = 2; // read command to read data.

   // transmit FIFO levels that stop and restart the readout.
   localparam int TX_HIGH_MARK = 16;
   localparam int TX_LOW_MARK  = 5;

   localparam int TX_DEPTH = 32;

endpackage

/* design/sample_fifo.sv */
`timescale 1ns/1ns

module sample_fifo #(
   parameter int DEPTH = 32
) (
   input  logic                       write_clk,
   input  logic                       rst,
   input  logic                       wr_en,
   input  fifo_sdram_pkg::sample_t    wr_data,
   input  logic                       rd_en,
   output fifo_sdram_pkg::sample_t    rd_data,
   output logic                       empty,
   output logic                       full,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   import fifo_sdram_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   sample_t          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_wr;
   logic             do_rd;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign do_wr   = wr_en && !full;  // a write into a full buffer is lost.
   assign do_rd   = rd_en && !empty;
   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(DEPTH));
   assign rd_data = mem[rd_ptr];     // the head word shows before it is popped.

   always_ff @(posedge write_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_rd)
            rd_ptr <= next_ptr(rd_ptr);
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // a push and a pop together leave the level.
         endcase
      end
   end

endmodule

/* design/fifo_sdram_scheduler.sv */
`timescale 1ns/1ns

module fifo_sdram_scheduler #(
   parameter int ADDR_WIDTH = 12,
   parameter int BLOCK_SIZE = 8,
   parameter int FILL_WORDS = 64,
   parameter int AQ_DEPTH   = 32
) (
   input  logic                                              write_clk,
   input  logic                                              rst,
   input  logic                                              spi_start_aq,
   input  logic [$clog2(AQ_DEPTH+1)-1:0]                     aq_count,
   input  fifo_sdram_pkg::sample_t                           aq_data,
   input  logic [fifo_sdram_pkg::NUM_BANKS-1:0]              bank_ready,
   input  logic [$clog2(fifo_sdram_pkg::TX_DEPTH+1)-1:0]     tx_count,
   input  logic                                              tx_empty,
   output logic                                              aq_write_en,
   output logic                                              aq_read_en,
   output logic                                              cmd_enable,
   output logic                                              cmd_wr,
   output logic [ADDR_WIDTH-1:0]                             cmd_address,
   output fifo_sdram_pkg::sample_t                           cmd_data,
   output logic                                              bb_filled,
   output logic                                              tx_ready_for_first_read,
   output logic                                              finished
);

   import fifo_sdram_pkg::*;

   localparam int AQ_CNT_W  = $clog2(AQ_DEPTH + 1);
   localparam int TX_CNT_W  = $clog2(TX_DEPTH + 1);
   localparam int BLK_CNT_W = $clog2(BLOCK_SIZE + 1);
   localparam int DRAIN     = BANK_LATENCY + 2;
   localparam int DRAIN_W   = $clog2(DRAIN + 1);

   localparam logic [AQ_CNT_W-1:0]   BLOCK_LEVEL = AQ_CNT_W'(BLOCK_SIZE);
   localparam logic [BLK_CNT_W-1:0]  BLOCK_LAST  = BLK_CNT_W'(BLOCK_SIZE);
   localparam logic [ADDR_WIDTH-1:0] FILL_ADDR   = ADDR_WIDTH'(FILL_WORDS);
   localparam logic [TX_CNT_W-1:0]   TX_HIGH     = TX_CNT_W'(TX_HIGH_MARK);
   localparam logic [TX_CNT_W-1:0]   TX_LOW      = TX_CNT_W'(TX_LOW_MARK);

   typedef enum logic [2:0] {
      AQ_WAITING,
      AQ_READ_ONE,
      AQ_FIFO_TO_MEM,
      TX_WRITING,
      TX_IDLE,
      FINISHED
   } state_t;

   state_t               state;
   logic [1:0]           sync_start;
   logic [BLK_CNT_W-1:0] block_cnt;
   logic [ADDR_WIDTH-1:0] wr_ptr;
   logic [ADDR_WIDTH-1:0] rd_ptr;
   logic [DRAIN_W-1:0]   drain_cnt;
   logic                 block_done;
   logic                 wr_done;
   logic                 rd_done;
   logic                 tx_high;
   logic                 tx_low;
   logic                 pop;
   logic                 issue_wr;
   logic                 issue_rd;

   // spi_start_aq comes from outside and passes two flops first.
   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         sync_start  <= 2'b00;
         aq_write_en <= 1'b0;
      end
      else
      begin
         sync_start <= {sync_start[0], spi_start_aq};
         if (sync_start[1])
            aq_write_en <= 1'b1; // stays set until reset.
      end
   end

   assign block_done = (block_cnt == BLOCK_LAST);
   assign wr_done    = (wr_ptr == FILL_ADDR);
   assign rd_done    = (rd_ptr == FILL_ADDR);
   assign tx_high    = (tx_count >= TX_HIGH);
   assign tx_low     = (tx_count < TX_LOW);

   // the !cmd_enable term keeps a gap of one cycle between commands.
   assign pop      = (state == AQ_READ_ONE) && !block_done;
   assign issue_wr = (state == AQ_FIFO_TO_MEM) && !cmd_enable &&
                     bank_ready[wr_ptr[BANK_SEL_WIDTH-1:0]];
   assign issue_rd = (state == TX_WRITING) && !cmd_enable && !rd_done && !tx_high &&
                     bank_ready[rd_ptr[BANK_SEL_WIDTH-1:0]];

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         state                   <= AQ_WAITING;
         block_cnt               <= '0;
         wr_ptr                  <= '0;
         rd_ptr                  <= '0;
         drain_cnt               <= '0;
         aq_read_en              <= 1'b0;
         cmd_enable              <= 1'b0;
         bb_filled               <= 1'b0;
         tx_ready_for_first_read <= 1'b0;
         finished                <= 1'b0;
      end
      else
      begin
         aq_read_en <= pop;
         cmd_enable <= issue_wr || issue_rd;
         if (issue_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (issue_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (tx_high)
            tx_ready_for_first_read <= 1'b1;

         case (state)
            AQ_WAITING:
            begin
               if (wr_done)
               begin
                  bb_filled <= 1'b1;
                  state     <= TX_WRITING;
               end
               else if (aq_count >= BLOCK_LEVEL)
               begin
                  block_cnt <= '0;
                  state     <= AQ_READ_ONE;
               end
            end
            AQ_READ_ONE:
            begin
               if (block_done)
                  state <= AQ_WAITING;
               else
               begin
                  block_cnt <= block_cnt + 1'b1;
                  state     <= AQ_FIFO_TO_MEM;
               end
            end
            AQ_FIFO_TO_MEM:
            begin
               if (issue_wr)
                  state <= AQ_READ_ONE;
            end
            TX_WRITING:
            begin
               if (rd_done || tx_high)
                  state <= TX_IDLE;
            end
            TX_IDLE:
            begin
               if (rd_done)
               begin
                  drain_cnt <= DRAIN_W'(DRAIN); // lets the last reads land.
                  state     <= FINISHED;
               end
               else if (tx_low)
                  state <= TX_WRITING;
            end
            FINISHED:
            begin
               if (drain_cnt != '0)
                  drain_cnt <= drain_cnt - 1'b1;
               else if (tx_empty)
                  finished <= 1'b1;
            end
            default: state <= AQ_WAITING;
         endcase
      end
   end

   // the popped head word waits here until its bank is ready.
   always_ff @(posedge write_clk)
   begin
      if (pop)
         cmd_data <= aq_data;
      if (issue_wr)
      begin
         cmd_wr      <= 1'b1;
         cmd_address <= wr_ptr;
      end
      else if (issue_rd)
      begin
         cmd_wr      <= 1'b0;
         cmd_address <= rd_ptr;
      end
   end

endmodule

/* design/sdram_bank.sv */
`timescale 1ns/1ns

module sdram_bank #(
   parameter int ADDR_WIDTH = 12,
   parameter int BANK_INDEX = 0
) (
   input  logic                    write_clk,
   input  logic                    rst,
   input  logic                    cmd_enable,
   input  logic                    cmd_wr,
   input  logic [ADDR_WIDTH-1:0]   cmd_address,
   input  fifo_sdram_pkg::sample_t cmd_data,
   output logic                    ready,
   output logic                    rd_valid,
   output fifo_sdram_pkg::sample_t rd_data
);

   import fifo_sdram_pkg::*;

   localparam int ROW_W  = ADDR_WIDTH - BANK_SEL_WIDTH;
   localparam int BUSY_W = $clog2(BANK_BUSY + 1);

   sample_t           mem [2**ROW_W];
   sample_t           data_pipe [BANK_LATENCY];
   logic [BANK_LATENCY-1:0] valid_pipe;
   logic [BUSY_W-1:0] busy_cnt;
   logic [ROW_W-1:0]  row;
   logic              hit;

   assign row   = cmd_address[ADDR_WIDTH-1:BANK_SEL_WIDTH];
   assign hit   = cmd_enable && ready &&
                  (cmd_address[BANK_SEL_WIDTH-1:0] == BANK_SEL_WIDTH'(BANK_INDEX));
   assign ready = (busy_cnt == '0);

   assign rd_valid = valid_pipe[BANK_LATENCY-1];
   assign rd_data  = data_pipe[BANK_LATENCY-1];

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         busy_cnt   <= '0;
         valid_pipe <= '0;
      end
      else
      begin
         if (hit)
            busy_cnt <= BUSY_W'(BANK_BUSY);
         else if (busy_cnt != '0)
            busy_cnt <= busy_cnt - 1'b1;
         valid_pipe <= BANK_LATENCY'({valid_pipe, hit && !cmd_wr}); // reads overlap in the pipe.
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (hit && cmd_wr)
         mem[row] <= cmd_data;
      if (hit && !cmd_wr)
         data_pipe[0] <= mem[row];
      for (int i = 1; i < BANK_LATENCY; i++)
         data_pipe[i] <= data_pipe[i-1];
   end

endmodule

/* design/read_return_collector.sv */
`timescale 1ns/1ns

module read_return_collector (
   input  logic                                   write_clk,
   input  logic                                   rst,
   input  logic [fifo_sdram_pkg::NUM_BANKS-1:0]   rd_valid,
   input  fifo_sdram_pkg::sample_t                rd_data [fifo_sdram_pkg::NUM_BANKS],
   input  logic                                   tx_full,
   output logic                                   tx_wr_en,
   output fifo_sdram_pkg::sample_t                tx_wr_data,
   output logic                                   tx_overrun
);

   import fifo_sdram_pkg::*;

   logic    sel_valid;
   sample_t sel_data;

   // commands are spaced, so at most one bank returns a word per cycle.
   always_comb
   begin
      sel_valid = 1'b0;
      sel_data  = '0;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
         if (rd_valid[b])
         begin
            sel_valid = 1'b1;
            sel_data  = rd_data[b];
         end
      end
   end

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         tx_wr_en   <= 1'b0;
         tx_overrun <= 1'b0;
      end
      else
      begin
         tx_wr_en <= sel_valid;
         if (tx_wr_en && tx_full)
            tx_overrun <= 1'b1; // the word is lost and the flag holds.
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (sel_valid)
         tx_wr_data <= sel_data;
   end

endmodule

/* design/fifo_sdram_top.sv */
`timescale 1ns/1ns

module fifo_sdram_top #(
   parameter int ADDR_WIDTH = 12,
   parameter int BLOCK_SIZE = 8,
   parameter int FILL_WORDS = 64,
   parameter int AQ_DEPTH   = 32
) (
   input  logic                    write_clk,
   input  logic                    rst,
   input  logic                    spi_start_aq,
   input  fifo_sdram_pkg::sample_t sample_in,
   input  logic                    sample_strobe,
   input  logic                    tx_read,
   output fifo_sdram_pkg::sample_t tx_data,
   output logic                    tx_empty,
   output logic                    aq_write_en,
   output logic                    bb_filled,
   output logic                    tx_ready_for_first_read,
   output logic                    finished,
   output logic                    tx_overrun
);

   import fifo_sdram_pkg::*;

   localparam int AQ_CNT_W = $clog2(AQ_DEPTH + 1);
   localparam int TX_CNT_W = $clog2(TX_DEPTH + 1);

   logic [AQ_CNT_W-1:0]   aq_count;
   sample_t               aq_data;
   logic                  aq_read_en;
   logic                  cmd_enable;
   logic                  cmd_wr;
   logic [ADDR_WIDTH-1:0] cmd_address;
   sample_t               cmd_data;
   logic [NUM_BANKS-1:0]  bank_ready;
   logic [NUM_BANKS-1:0]  bank_rd_valid;
   sample_t               bank_rd_data [NUM_BANKS];
   logic                  tx_wr_en;
   sample_t               tx_wr_data;
   logic                  tx_full;
   logic [TX_CNT_W-1:0]   tx_count;

   sample_fifo #(.DEPTH(AQ_DEPTH)) i_aq_fifo (
      .write_clk (write_clk),
      .rst       (rst),
      .wr_en     (sample_strobe && aq_write_en), // early samples are dropped.
      .wr_data   (sample_in),
      .rd_en     (aq_read_en),
      .rd_data   (aq_data),
      .empty     (),
      .full      (),
      .count     (aq_count)
   );

   fifo_sdram_scheduler #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .BLOCK_SIZE (BLOCK_SIZE),
      .FILL_WORDS (FILL_WORDS),
      .AQ_DEPTH   (AQ_DEPTH)
   ) i_scheduler (
      .write_clk               (write_clk),
      .rst                     (rst),
      .spi_start_aq            (spi_start_aq),
      .aq_count                (aq_count),
      .aq_data                 (aq_data),
      .bank_ready              (bank_ready),
      .tx_count                (tx_count),
      .tx_empty                (tx_empty),
      .aq_write_en             (aq_write_en),
      .aq_read_en              (aq_read_en),
      .cmd_enable              (cmd_enable),
      .cmd_wr                  (cmd_wr),
      .cmd_address             (cmd_address),
      .cmd_data                (cmd_data),
      .bb_filled               (bb_filled),
      .tx_ready_for_first_read (tx_ready_for_first_read),
      .finished                (finished)
   );

   for (genvar g = 0; g < NUM_BANKS; g++)
   begin : g_bank
      sdram_bank #(.ADDR_WIDTH(ADDR_WIDTH), .BANK_INDEX(g)) i_bank (
         .write_clk   (write_clk),
         .rst         (rst),
         .cmd_enable  (cmd_enable),
         .cmd_wr      (cmd_wr),
         .cmd_address (cmd_address),
         .cmd_data    (cmd_data),
         .ready       (bank_ready[g]),
         .rd_valid    (bank_rd_valid[g]),
         .rd_data     (bank_rd_data[g])
      );
   end

   read_return_collector i_collector (
      .write_clk  (write_clk),
      .rst        (rst),
      .rd_valid   (bank_rd_valid),
      .rd_data    (bank_rd_data),
      .tx_full    (tx_full),
      .tx_wr_en   (tx_wr_en),
      .tx_wr_data (tx_wr_data),
      .tx_overrun (tx_overrun)
   );

   sample_fifo #(.DEPTH(TX_DEPTH)) i_tx_fifo (
      .write_clk (write_clk),
      .rst       (rst),
      .wr_en     (tx_wr_en),
      .wr_data   (tx_wr_data),
      .rd_en     (tx_read),
      .rd_data   (tx_data),
      .empty     (tx_empty),
      .full      (tx_full),
      .count     (tx_count)
   );

endmodule

/* verif/fifo_sdram_tb.sv */
`timescale 1ns/1ns

module fifo_sdram_tb;

   import fifo_sdram_pkg::*;

   localparam int ADDR_WIDTH = 12;
   localparam int BLOCK_SIZE = 8;
   localparam int FILL_WORDS = 64;
   localparam int AQ_DEPTH   = 32;

   localparam int START_DELAY = 12;
   localparam int HOLD_CYCLES = 60;
   localparam int TAIL_CYCLES = 30;
   // about 7 cycles per stored word and 3 per popped word, with a wide margin.
   localparam int WATCHDOG_CYCLES = 8 + START_DELAY + FILL_WORDS * 24 + HOLD_CYCLES +
                                    FILL_WORDS * 8 + TAIL_CYCLES + 200;

   logic        write_clk;
   logic        rst;
   logic        spi_start_aq;
   sample_t     sample_in;
   logic        sample_strobe;
   logic        tx_read;
   sample_t     tx_data;
   logic        tx_empty;
   logic        aq_write_en;
   logic        bb_filled;
   logic        tx_ready_for_first_read;
   logic        finished;
   logic        tx_overrun;

   logic [15:0] lfsr_state   = 16'd93;
   sample_t     ref_q [$];
   sample_t     exp_word     = '0;
   logic        exp_ok       = 1'b0;
   logic        pop_pending  = 1'b0;
   logic        aq_open      = 1'b0;
   logic        read_random  = 1'b0;
   int          strobe_gap   = 0;
   int          start_cycles = 0;
   int          reset_cycles = 0;
   int          queued_total = 0;
   int          popped       = 0;
   int          data_errors  = 0;
   int          ctrl_errors  = 0;

   fifo_sdram_top #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .BLOCK_SIZE (BLOCK_SIZE),
      .FILL_WORDS (FILL_WORDS),
      .AQ_DEPTH   (AQ_DEPTH)
   ) i_dut (
      .write_clk               (write_clk),
      .rst                     (rst),
      .spi_start_aq            (spi_start_aq),
      .sample_in               (sample_in),
      .sample_strobe           (sample_strobe),
      .tx_read                 (tx_read),
      .tx_data                 (tx_data),
      .tx_empty                (tx_empty),
      .aq_write_en             (aq_write_en),
      .bb_filled               (bb_filled),
      .tx_ready_for_first_read (tx_ready_for_first_read),
      .finished                (finished),
      .tx_overrun              (tx_overrun)
   );

   function automatic logic [15:0] galois_step(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      return s >> 1;
   endfunction

   function automatic logic [15:0] next_bits(input int n);
      logic [15:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits       = {bits[14:0], lfsr_state[0]};
         lfsr_state = galois_step(lfsr_state); // one step per bit taken.
      end
      return bits;
   endfunction

   task automatic report_error(input bit is_data, input string msg);
      if (is_data)
         data_errors++;
      else
         ctrl_errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic print_counts();
      $display("summary: %0d data errors, %0d control errors, %0d of %0d words popped",
               data_errors, ctrl_errors, popped, FILL_WORDS);
   endtask

   initial
   begin
      write_clk = 1'b0;
      forever
         #2 write_clk = ~write_clk;
   end

   always @(posedge write_clk)
   begin
      if (rst)
      begin
         sample_strobe <= 1'b0;
         tx_read       <= 1'b0;
         strobe_gap    <= 0;
         reset_cycles  <= reset_cycles + 1;
      end
      else
      begin
         sample_strobe <= 1'b0;
         strobe_gap    <= strobe_gap + 1;
         if (spi_start_aq)
            start_cycles <= start_cycles + 1;
         // before the start every chance is taken, so early strobes surely occur.
         if (strobe_gap >= 3 && queued_total < FILL_WORDS &&
             (!aq_open || next_bits(2) == 16'd0))
         begin
            sample_strobe <= 1'b1;
            sample_in     <= next_bits(16);
            strobe_gap    <= 0;
         end
         tx_read <= read_random ? (next_bits(1) != 16'd0) : 1'b0;
      end
   end

   // mid-cycle view of what the next rising edge will do.
   always @(negedge write_clk)
   begin
      aq_open     = aq_write_en;
      pop_pending = 1'b0;
      if (!rst)
      begin
         if (sample_strobe && start_cycles >= 3)
         begin
            ref_q.push_back(sample_in);
            queued_total++;
         end
         if (tx_read && !tx_empty)
         begin
            pop_pending = 1'b1;
            popped++;
            exp_ok = (ref_q.size() > 0);
            if (exp_ok)
               exp_word = ref_q.pop_front();
         end
      end
   end

   assert property (@(posedge write_clk) (rst && reset_cycles >= 2) |->
                    !(aq_write_en || bb_filled || tx_ready_for_first_read ||
                      finished || tx_overrun))
      else report_error(1'b0, "a status output is high during reset");

   assert property (@(posedge write_clk) disable iff (rst)
                    aq_write_en == (start_cycles >= 3))
      else report_error(1'b0, "aq_write_en does not rise 3 cycles after the start request");

   assert property (@(posedge write_clk) disable iff (rst) pop_pending |-> exp_ok)
      else report_error(1'b1, "a tx word appeared that was never written");

   assert property (@(posedge write_clk) disable iff (rst)
                    (pop_pending && exp_ok) |-> (tx_data == exp_word))
      else report_error(1'b1, "tx word differs from the reference queue head");

   assert property (@(posedge write_clk) disable iff (rst)
                    bb_filled |-> (queued_total >= FILL_WORDS))
      else report_error(1'b0, "bb_filled rose before enough samples were written");

   assert property (@(posedge write_clk) disable iff (rst) !tx_empty |-> bb_filled)
      else report_error(1'b0, "a tx word is present before bb_filled");

   assert property (@(posedge write_clk) disable iff (rst) bb_filled |=> bb_filled)
      else report_error(1'b0, "bb_filled fell");

   assert property (@(posedge write_clk) disable iff (rst)
                    tx_ready_for_first_read |=> tx_ready_for_first_read)
      else report_error(1'b0, "tx_ready_for_first_read fell");

   assert property (@(posedge write_clk) disable iff (rst) popped <= FILL_WORDS)
      else report_error(1'b1, "more words popped than were stored");

   assert property (@(posedge write_clk) disable iff (rst) !tx_overrun)
      else report_error(1'b0, "tx_overrun went high");

   assert property (@(posedge write_clk) disable iff (rst)
                    finished |-> (popped == FILL_WORDS && tx_empty))
      else report_error(1'b0, "finished is high with words missing or still queued");

   initial
   begin
      rst           = 1'b1;
      spi_start_aq  = 1'b0;
      sample_in     = '0;
      sample_strobe = 1'b0;
      tx_read       = 1'b0;
      repeat (8) @(posedge write_clk);
      rst <= 1'b0;
      repeat (START_DELAY) @(posedge write_clk);
      spi_start_aq <= 1'b1;
      while (!tx_ready_for_first_read) // tx_read is still held low here.
         @(negedge write_clk);
      repeat (HOLD_CYCLES) @(posedge write_clk);
      read_random <= 1'b1;
      while (!finished)
         @(negedge write_clk);
      repeat (TAIL_CYCLES) @(posedge write_clk);
      print_counts();
      if (data_errors + ctrl_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge write_clk);
      $display("Watchdog expired after %0d cycles: the run hung before finished rose.",
               WATCHDOG_CYCLES);
      print_counts();
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* compile.f */
design/fifo_sdram_pkg.sv
design/sample_fifo.sv
design/fifo_sdram_scheduler.sv
design/sdram_bank.sv
design/read_return_collector.sv
design/fifo_sdram_top.sv
verif/fifo_sdram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module fifo_sdram_tb -f compile.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vfifo_sdram_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
   exit 0
fi
exit 1
